/* logic/cpu_macros.svh */
// Width and depth defines shared by the CPU back end packages and RTL
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Data and address width in bits
`define WORD_W 32

// Register index width, 32 architectural registers
`define REG_W 5

// Number of words held in the data RAM
`define DMEM_WORDS 256

// Instruction field widths
`define OPCODE_W 6
`define FUNCT_W 6
`define JADDR_W 26
`define SHAMT_W 5

// Encoding width of the ALU operation
`define ALUOP_W 4

`endif

/* logic/cpu_types_pkg.sv */
// Basic CPU types: word, register index, opcode, funct and ALU operation enums
`include "cpu_macros.svh"

package cpu_types_pkg;

    typedef logic [`WORD_W-1:0] word_t;
    typedef logic [`REG_W-1:0] regbits_t;

    // Primary opcode field of the MIPS encoding
    typedef enum logic [`OPCODE_W-1:0] {
        RTYPE = 6'b000000,
        J     = 6'b000010,
        JAL   = 6'b000011,
        BEQ   = 6'b000100,
        BNE   = 6'b000101,
        ADDI  = 6'b001000,
        ADDIU = 6'b001001,
        SLTI  = 6'b001010,
        SLTIU = 6'b001011,
        ANDI  = 6'b001100,
        ORI   = 6'b001101,
        XORI  = 6'b001110,
        LUI   = 6'b001111,
        LW    = 6'b100011,
        SW    = 6'b101011,
        HALT  = 6'b111111
    } opcode_t;

    // Function field for RTYPE instructions
    typedef enum logic [`FUNCT_W-1:0] {
        SLL  = 6'b000000,
        SRL  = 6'b000010,
        JR   = 6'b001000,
        ADD  = 6'b100000,
        ADDU = 6'b100001,
        SUB  = 6'b100010,
        SUBU = 6'b100011,
        AND  = 6'b100100,
        OR   = 6'b100101,
        XOR  = 6'b100110,
        NOR  = 6'b100111,
        SLT  = 6'b101010,
        SLTU = 6'b101011
    } funct_t;

    typedef enum logic [`ALUOP_W-1:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_NOR  = 4'd5,
        ALU_SLT  = 4'd6,
        ALU_SLTU = 4'd7,
        ALU_SLL  = 4'd8,
        ALU_SRL  = 4'd9
    } aluop_t;

endpackage

/* logic/pipe_pkg.sv */
// Inter-stage bundle structs for the ID/EX, EX/MEM and MEM/WB latches
`include "cpu_macros.svh"

package pipe_pkg;

    // Decoded instruction with its register operands already read
    typedef struct packed {
        logic                  valid;
        cpu_types_pkg::word_t  pcplusfour;
        cpu_types_pkg::word_t  rdat1;
        cpu_types_pkg::word_t  rdat2;
        cpu_types_pkg::word_t  imm;          // Sign or zero extended by decode
        logic [`JADDR_W-1:0]   j_addr;
        logic [`SHAMT_W-1:0]   shift_amt;
        cpu_types_pkg::regbits_t wsel;
        cpu_types_pkg::aluop_t aluop;
        logic                  alusrc;
        logic                  beq;
        logic                  bne;
        logic                  jump;
        logic                  jr;
        logic                  jal;
        logic                  lui;
        logic                  dREN;
        logic                  dWEN;
        logic                  MemtoReg;
        logic                  RegWr;
        logic                  halt;
    } id_ex_t;

    // After execute, branch and jump fields are no longer needed
    typedef struct packed {
        logic                    valid;
        cpu_types_pkg::word_t    alu_out;
        cpu_types_pkg::word_t    rdat2;       // Store data
        cpu_types_pkg::word_t    pcplusfour;
        cpu_types_pkg::regbits_t wsel;
        logic                    dREN;
        logic                    dWEN;
        logic                    MemtoReg;
        logic                    RegWr;
        logic                    jal;
        logic                    halt;
    } ex_mem_t;

    typedef struct packed {
        logic                    valid;
        cpu_types_pkg::word_t    alu_out;
        cpu_types_pkg::word_t    dload;
        cpu_types_pkg::word_t    pcplusfour;
        cpu_types_pkg::regbits_t wsel;
        logic                    MemtoReg;
        logic                    RegWr;
        logic                    jal;
        logic                    halt;
    } mem_wb_t;

endpackage

/* logic/pipe_latch.sv */
// Pipeline register for any bundle type, with load enable and flush
module pipe_latch #(
    parameter type payload_t = logic
) (
    input  logic     CLK,
    input  logic     nRST,
    input  logic     en,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            q <= '0;           // All zero leaves the valid bit clear
        end else if (flush) begin
            q <= '0;
        end else if (en) begin
            q <= d;
        end
    end

endmodule

/* logic/execute_stage.sv */
// Execute stage: ALU, lui and shifts, branch and jump resolution, redirect
module execute_stage (
    input  pipe_pkg::id_ex_t     ex,
    output pipe_pkg::ex_mem_t    mem,
    output logic                 redirect,
    output cpu_types_pkg::word_t redirect_pc
);

    cpu_types_pkg::word_t op_a;
    cpu_types_pkg::word_t op_b;
    cpu_types_pkg::word_t alu_res;
    cpu_types_pkg::word_t branch_pc;
    cpu_types_pkg::word_t jump_pc;
    logic                 br_taken;

    assign op_a = ex.rdat1;
    assign op_b = ex.alusrc ? ex.imm : ex.rdat2;

    always_comb begin
        unique case (ex.aluop)
            cpu_types_pkg::ALU_ADD:  alu_res = op_a + op_b;
            cpu_types_pkg::ALU_SUB:  alu_res = op_a - op_b;
            cpu_types_pkg::ALU_AND:  alu_res = op_a & op_b;
            cpu_types_pkg::ALU_OR:   alu_res = op_a | op_b;
            cpu_types_pkg::ALU_XOR:  alu_res = op_a ^ op_b;
            cpu_types_pkg::ALU_NOR:  alu_res = ~(op_a | op_b);
            cpu_types_pkg::ALU_SLT:  alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            cpu_types_pkg::ALU_SLTU: alu_res = {31'b0, op_a < op_b};
            cpu_types_pkg::ALU_SLL:  alu_res = op_b << ex.shift_amt;  // Shifts act on rt
            cpu_types_pkg::ALU_SRL:  alu_res = op_b >> ex.shift_amt;
            default:                 alu_res = '0;
        endcase
    end

    // Branches compare the two register operands, never the immediate
    assign br_taken = (ex.beq && (ex.rdat1 == ex.rdat2)) ||
                      (ex.bne && (ex.rdat1 != ex.rdat2));

    assign branch_pc = ex.pcplusfour + {ex.imm[29:0], 2'b00};
    assign jump_pc   = {ex.pcplusfour[31:28], ex.j_addr, 2'b00};

    always_comb begin
        redirect    = 1'b0;
        redirect_pc = '0;
        if (ex.valid) begin
            if (ex.jr) begin
                redirect    = 1'b1;
                redirect_pc = ex.rdat1;
            end else if (ex.jump || ex.jal) begin
                redirect    = 1'b1;
                redirect_pc = jump_pc;
            end else if (br_taken) begin
                redirect    = 1'b1;
                redirect_pc = branch_pc;
            end
        end
    end

    always_comb begin
        mem.valid      = ex.valid;
        mem.alu_out    = ex.lui ? {ex.imm[15:0], 16'h0000} : alu_res;
        mem.rdat2      = ex.rdat2;
        mem.pcplusfour = ex.pcplusfour;
        mem.wsel       = ex.wsel;
        mem.dREN       = ex.dREN;
        mem.dWEN       = ex.dWEN;
        mem.MemtoReg   = ex.MemtoReg;
        mem.RegWr      = ex.RegWr;
        mem.jal        = ex.jal;
        mem.halt       = ex.halt;
    end

endmodule

/* logic/memory_stage.sv */
// Memory stage: single-cycle data RAM with combinational read and clocked write
`include "cpu_macros.svh"

module memory_stage (
    input  logic              CLK,
    input  logic              nRST,
    input  pipe_pkg::ex_mem_t mem,
    output pipe_pkg::mem_wb_t wb
);

    localparam int ADDR_W = $clog2(`DMEM_WORDS);

    cpu_types_pkg::word_t ram [`DMEM_WORDS];
    logic [ADDR_W-1:0]    word_idx;
    logic                 rd_en;
    logic                 wr_en;

    // Byte address to word index, wrapping at the RAM depth
    assign word_idx = mem.alu_out[ADDR_W+1:2];

    assign rd_en = mem.valid && mem.dREN;
    assign wr_en = mem.valid && mem.dWEN;

    // Cleared on reset so unwritten locations read back as zero
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < `DMEM_WORDS; i++) begin
                ram[i] <= '0;
            end
        end else if (wr_en) begin
            ram[word_idx] <= mem.rdat2;
        end
    end

    always_comb begin
        wb.valid      = mem.valid;
        wb.alu_out    = mem.alu_out;
        wb.dload      = rd_en ? ram[word_idx] : '0;
        wb.pcplusfour = mem.pcplusfour;
        wb.wsel       = mem.wsel;
        wb.MemtoReg   = mem.MemtoReg;
        wb.RegWr      = mem.RegWr;
        wb.jal        = mem.jal;
        wb.halt       = mem.halt;
    end

endmodule

/* logic/writeback_stage.sv */
// Writeback stage: result select, register write strobe and sticky halt flag
module writeback_stage (
    input  logic                    CLK,
    input  logic                    nRST,
    input  pipe_pkg::mem_wb_t       wb,
    output logic                    halted,
    output logic                    reg_wen,
    output cpu_types_pkg::regbits_t reg_wsel,
    output cpu_types_pkg::word_t    reg_wdat
);

    logic halt_q;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            halt_q <= 1'b0;
        end else if (wb.valid && wb.halt) begin
            halt_q <= 1'b1;
        end
    end

    // High as soon as the halt bundle reaches writeback
    assign halted = halt_q || (wb.valid && wb.halt);

    assign reg_wsel = wb.jal ? 5'd31 : wb.wsel;    // jal links into ra

    assign reg_wdat = wb.jal      ? wb.pcplusfour :
                      wb.MemtoReg ? wb.dload      :
                                    wb.alu_out;

    assign reg_wen = wb.valid && wb.RegWr && (reg_wsel != '0) && !halted;

endmodule

/* logic/exec_backend.sv */
// Top level chaining the ID/EX, EX/MEM and MEM/WB latches with their stages
module exec_backend (
    input  logic                    CLK,
    input  logic                    nRST,
    input  pipe_pkg::id_ex_t        id_in,
    output logic                    redirect,
    output cpu_types_pkg::word_t    redirect_pc,
    output logic                    reg_wen,
    output cpu_types_pkg::regbits_t reg_wsel,
    output cpu_types_pkg::word_t    reg_wdat,
    output logic                    halted
);

    pipe_pkg::id_ex_t  idex_q;
    pipe_pkg::ex_mem_t ex_out;
    pipe_pkg::ex_mem_t exmem_q;
    pipe_pkg::mem_wb_t mem_out;
    pipe_pkg::mem_wb_t memwb_q;
    logic              run;

    assign run = !halted;    // The whole back end freezes once halted

    pipe_latch #(.payload_t(pipe_pkg::id_ex_t)) u_idex (
        .CLK   (CLK),
        .nRST  (nRST),
        .en    (run),
        .flush (redirect),   // Drops the bundle behind a taken control transfer
        .d     (id_in),
        .q     (idex_q)
    );

    execute_stage u_execute (
        .ex          (idex_q),
        .mem         (ex_out),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    pipe_latch #(.payload_t(pipe_pkg::ex_mem_t)) u_exmem (
        .CLK   (CLK),
        .nRST  (nRST),
        .en    (run),
        .flush (1'b0),
        .d     (ex_out),
        .q     (exmem_q)
    );

    memory_stage u_memory (
        .CLK  (CLK),
        .nRST (nRST),
        .mem  (exmem_q),
        .wb   (mem_out)
    );

    pipe_latch #(.payload_t(pipe_pkg::mem_wb_t)) u_memwb (
        .CLK   (CLK),
        .nRST  (nRST),
        .en    (run),
        .flush (1'b0),
        .d     (mem_out),
        .q     (memwb_q)
    );

    writeback_stage u_writeback (
        .CLK      (CLK),
        .nRST     (nRST),
        .wb       (memwb_q),
        .halted   (halted),
        .reg_wen  (reg_wen),
        .reg_wsel (reg_wsel),
        .reg_wdat (reg_wdat)
    );

endmodule

/* verif/clock_gen.sv */
// Testbench clock and reset source with an 8 unit clock period
module clock_gen (
    output logic CLK,
    output logic nRST
);

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    initial begin
        nRST = 1'b0;
        repeat (10) @(posedge CLK);
        #1 nRST = 1'b1;    // Released just after an edge, away from the latch updates
    end

endmodule

/* verif/backend_checker.sv */
// Output checker with expectation queues for redirect and register write results
module backend_checker (
    input logic                    CLK,
    input logic                    redirect,
    input cpu_types_pkg::word_t    redirect_pc,
    input logic                    reg_wen,
    input cpu_types_pkg::regbits_t reg_wsel,
    input cpu_types_pkg::word_t    reg_wdat,
    input logic                    halted
);

    typedef struct packed {
        int unsigned          due;
        logic                 red;
        cpu_types_pkg::word_t rpc;
    } red_exp_t;

    typedef struct packed {
        int unsigned             due;
        logic                    wen;
        cpu_types_pkg::regbits_t wsel;
        cpu_types_pkg::word_t    wdat;
        logic                    halt;
    } wr_exp_t;

    red_exp_t    red_q[$];
    wr_exp_t     wr_q[$];
    red_exp_t    red_e;
    wr_exp_t     wr_e;
    int unsigned cyc = 0;
    int          checks = 0;
    int          errors = 0;

    // A bundle pushed after edge k shows its redirect before edge k+2, its write before k+4
    task automatic push_expect(input logic red, input cpu_types_pkg::word_t rpc,
                               input logic wen, input cpu_types_pkg::regbits_t wsel,
                               input cpu_types_pkg::word_t wdat, input logic halt);
        red_q.push_back('{cyc + 2, red, rpc});
        wr_q.push_back('{cyc + 4, wen, wsel, wdat, halt});
    endtask

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] t=%0t %s expected %0h got %0h", $time, name, exp, got);
        end
    endtask

    always @(posedge CLK) begin
        while (red_q.size() > 0 && red_q[0].due == cyc + 1) begin
            red_e = red_q.pop_front();
            check_val("redirect", red_e.red, redirect);
            if (red_e.red) begin
                check_val("redirect_pc", red_e.rpc, redirect_pc);
            end
        end
        while (wr_q.size() > 0 && wr_q[0].due == cyc + 1) begin
            wr_e = wr_q.pop_front();
            check_val("reg_wen", wr_e.wen, reg_wen);
            check_val("halted", wr_e.halt, halted);
            if (wr_e.wen) begin
                check_val("reg_wsel", wr_e.wsel, reg_wsel);
                check_val("reg_wdat", wr_e.wdat, reg_wdat);
            end
        end
        cyc = cyc + 1;
    end

endmodule

/* verif/tb_exec_backend.sv */
// Testbench top with the stimulus table, drive loop, watchdog and final report
module tb_exec_backend;

    typedef struct packed {
        pipe_pkg::id_ex_t        bd;
        logic                    red;
        cpu_types_pkg::word_t    rpc;
        logic                    wen;
        cpu_types_pkg::regbits_t wsel;
        cpu_types_pkg::word_t    wdat;
        logic                    halt;
    } row_t;

    logic                    CLK;
    logic                    nRST;
    pipe_pkg::id_ex_t        id_in;
    logic                    redirect;
    cpu_types_pkg::word_t    redirect_pc;
    logic                    reg_wen;
    cpu_types_pkg::regbits_t reg_wsel;
    cpu_types_pkg::word_t    reg_wdat;
    logic                    halted;
    row_t                    table_q[$];
    logic                    built = 1'b0;
    int                      seed = 78212;

    clock_gen u_clock (.CLK(CLK), .nRST(nRST));

    exec_backend u_exec_backend (
        .CLK(CLK), .nRST(nRST), .id_in(id_in), .redirect(redirect),
        .redirect_pc(redirect_pc), .reg_wen(reg_wen), .reg_wsel(reg_wsel),
        .reg_wdat(reg_wdat), .halted(halted)
    );

    backend_checker u_checker (
        .CLK(CLK), .redirect(redirect), .redirect_pc(redirect_pc), .reg_wen(reg_wen),
        .reg_wsel(reg_wsel), .reg_wdat(reg_wdat), .halted(halted)
    );

    function automatic pipe_pkg::id_ex_t alu_bundle(input cpu_types_pkg::aluop_t op,
            input logic [31:0] a, input logic [31:0] b, input logic [31:0] imm,
            input logic alusrc, input logic [4:0] wsel);
        pipe_pkg::id_ex_t r;
        r            = '0;
        r.valid      = 1'b1;
        r.pcplusfour = 32'h0000_0100;
        r.aluop      = op;
        r.rdat1      = a;
        r.rdat2      = b;
        r.imm        = imm;
        r.alusrc     = alusrc;
        r.wsel       = wsel;
        r.RegWr      = 1'b1;
        return r;
    endfunction

    function automatic pipe_pkg::id_ex_t ctl_bundle(input logic [31:0] pc,
            input logic [31:0] a, input logic [31:0] b, input logic [31:0] imm,
            input logic [25:0] j_addr);
        pipe_pkg::id_ex_t r;
        r            = alu_bundle(cpu_types_pkg::ALU_ADD, a, b, imm, 1'b0, 5'd0);
        r.pcplusfour = pc;
        r.j_addr     = j_addr;
        r.RegWr      = 1'b0;
        return r;
    endfunction

    task automatic add_row(input pipe_pkg::id_ex_t bd, input logic red, input logic [31:0] rpc,
                           input logic wen, input logic [4:0] wsel, input logic [31:0] wdat,
                           input logic halt);
        table_q.push_back('{bd, red, rpc, wen, wsel, wdat, halt});
    endtask

    task automatic build_table();
        logic [31:0]      a;
        logic [31:0]      b;
        pipe_pkg::id_ex_t bd;
        pipe_pkg::id_ex_t flushed;
        a = $random(seed);
        b = $random(seed);
        flushed = alu_bundle(cpu_types_pkg::ALU_ADD, a, b, 0, 1'b0, 5'd13);
        add_row('0, 0, 0, 0, 0, 0, 0);                        // Quiet after reset
        add_row('0, 0, 0, 0, 0, 0, 0);
        add_row(alu_bundle(cpu_types_pkg::ALU_ADD, a, b, 0, 0, 1), 0, 0, 1, 1, a + b, 0);
        add_row(alu_bundle(cpu_types_pkg::ALU_SUB, a, b, 0, 0, 2), 0, 0, 1, 2, a - b, 0);
        add_row(alu_bundle(cpu_types_pkg::ALU_AND, a, b, 0, 0, 3), 0, 0, 1, 3, a & b, 0);
        add_row(alu_bundle(cpu_types_pkg::ALU_OR, a, b, 32'hf0f0, 1, 4), 0, 0, 1, 4,
                a | 32'hf0f0, 0);
        add_row(alu_bundle(cpu_types_pkg::ALU_XOR, a, b, 0, 0, 5), 0, 0, 1, 5, a ^ b, 0);
        add_row(alu_bundle(cpu_types_pkg::ALU_NOR, a, b, 0, 0, 6), 0, 0, 1, 6, ~(a | b), 0);
        add_row(alu_bundle(cpu_types_pkg::ALU_SLT, -5, 3, 0, 0, 7), 0, 0, 1, 7, 1, 0);
        add_row(alu_bundle(cpu_types_pkg::ALU_SLTU, -5, 3, 0, 0, 7), 0, 0, 1, 7, 0, 0);
        bd = alu_bundle(cpu_types_pkg::ALU_SLL, 0, b, 0, 0, 8);
        bd.shift_amt = 5;
        add_row(bd, 0, 0, 1, 8, b << 5, 0);
        bd = alu_bundle(cpu_types_pkg::ALU_SRL, 0, b, 0, 0, 9);
        bd.shift_amt = 7;
        add_row(bd, 0, 0, 1, 9, b >> 7, 0);
        bd = alu_bundle(cpu_types_pkg::ALU_ADD, 0, 0, 32'h1234, 1, 10);
        bd.lui = 1'b1;
        add_row(bd, 0, 0, 1, 10, 32'h1234_0000, 0);
        add_row(alu_bundle(cpu_types_pkg::ALU_ADD, a, b, 0, 0, 0), 0, 0, 0, 0, 0, 0);
        bd = alu_bundle(cpu_types_pkg::ALU_ADD, 32'h100, 32'hcafe_f00d, 8, 1, 0);
        bd.RegWr = 1'b0;
        bd.dWEN  = 1'b1;
        add_row(bd, 0, 0, 0, 0, 0, 0);                        // Store to byte address 0x108
        bd = alu_bundle(cpu_types_pkg::ALU_ADD, 32'h104, 0, 4, 1, 11);
        bd.dREN     = 1'b1;
        bd.MemtoReg = 1'b1;
        add_row(bd, 0, 0, 1, 11, 32'hcafe_f00d, 0);
        bd.rdat1 = 32'h200;
        bd.imm   = 0;
        bd.wsel  = 12;
        add_row(bd, 0, 0, 1, 12, 0, 0);                       // Never written
        bd = ctl_bundle(32'h400, 7, 7, 3, 0);
        bd.beq = 1'b1;
        add_row(bd, 1, 32'h400 + (32'd3 << 2), 0, 0, 0, 0);
        add_row(flushed, 0, 0, 0, 0, 0, 0);
        bd.rdat2 = 8;
        add_row(bd, 0, 0, 0, 0, 0, 0);
        bd = ctl_bundle(32'h500, 7, 8, 32'hffff_fffe, 0);
        bd.bne = 1'b1;
        add_row(bd, 1, 32'h0000_04f8, 0, 0, 0, 0);
        add_row(flushed, 0, 0, 0, 0, 0, 0);
        bd.rdat2 = 7;
        add_row(bd, 0, 0, 0, 0, 0, 0);
        bd = ctl_bundle(32'h9000_0010, 0, 0, 0, 26'h40);
        bd.jump = 1'b1;
        add_row(bd, 1, 32'h9000_0100, 0, 0, 0, 0);
        add_row(flushed, 0, 0, 0, 0, 0, 0);
        bd = ctl_bundle(32'h700, 32'h00ab_c000, 0, 0, 0);
        bd.jr = 1'b1;
        add_row(bd, 1, 32'h00ab_c000, 0, 0, 0, 0);
        add_row(flushed, 0, 0, 0, 0, 0, 0);
        bd = ctl_bundle(32'h600, 0, 0, 0, 26'h123);
        bd.jal   = 1'b1;
        bd.RegWr = 1'b1;
        add_row(bd, 1, 32'h0000_048c, 1, 31, 32'h600, 0);
        add_row(flushed, 0, 0, 0, 0, 0, 0);
        add_row(alu_bundle(cpu_types_pkg::ALU_ADD, a, b, 0, 0, 14), 0, 0, 1, 14, a + b, 0);
        bd = '0;
        bd.valid = 1'b1;
        bd.halt  = 1'b1;
        add_row(bd, 0, 0, 0, 0, 0, 1);
        add_row(alu_bundle(cpu_types_pkg::ALU_ADD, a, b, 0, 0, 15), 0, 0, 0, 0, 0, 1);
        add_row(alu_bundle(cpu_types_pkg::ALU_ADD, a, b, 0, 0, 16), 0, 0, 0, 0, 0, 1);
    endtask

    initial begin
        id_in = '0;
        build_table();
        built = 1'b1;
        wait (nRST === 1'b1);
        @(posedge CLK);
        foreach (table_q[i]) begin
            #1 id_in = table_q[i].bd;
            u_checker.push_expect(table_q[i].red, table_q[i].rpc, table_q[i].wen,
                                  table_q[i].wsel, table_q[i].wdat, table_q[i].halt);
            @(posedge CLK);
        end
        #1 id_in = '0;
        repeat (5) @(posedge CLK);
        $display("Checks: %0d, errors: %0d", u_checker.checks, u_checker.errors);
        if (u_checker.errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        wait (built);
        #((table_q.size() + 20) * 8);
        $display("Timeout: the test did not finish in the expected time");
        $display("Simulation FAILED");
        $finish;
    end

endmodule

/* exec_backend.f */
+incdir+logic
logic/cpu_types_pkg.sv
logic/pipe_pkg.sv
logic/pipe_latch.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/writeback_stage.sv
logic/exec_backend.sv
verif/clock_gen.sv
verif/backend_checker.sv
verif/tb_exec_backend.sv

/* Bender.yml */
package:
  name: exec_backend

sources:
  - include_dirs:
      - logic
    files:
      - logic/cpu_types_pkg.sv
      - logic/pipe_pkg.sv
      - logic/pipe_latch.sv
      - logic/execute_stage.sv
      - logic/memory_stage.sv
      - logic/writeback_stage.sv
      - logic/exec_backend.sv
  - target: simulation
    files:
      - verif/clock_gen.sv
      - verif/backend_checker.sv
      - verif/tb_exec_backend.sv
